// File: run_sim.sh
#!/bin/sh
# build the laser servo testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_laser_servo \
	-f vlog.f -Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_laser_servo > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log \
	&& { echo "simulation reported failures, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// File: source/adc_capture.sv
// input side of the servo; registers samples and config words, decodes fields, drives the AFE pins
`timescale 1ns/10ps

module adc_capture (
	input  logic                                   clk1,
	input  logic                                   i_arst_n,
	input  logic        [servo_pkg::RAW_W-1:0]     i_adc0_data,
	input  logic        [servo_pkg::RAW_W-1:0]     i_adc1_data,
	input  logic        [servo_pkg::CFG_W-1:0]     i_cfg0,
	input  logic        [servo_pkg::CFG_W-1:0]     i_cfg1,
	output logic        [servo_pkg::RAW_W-1:0]     o_raw0,
	output logic        [servo_pkg::RAW_W-1:0]     o_raw1,
	output logic        [servo_pkg::N_CH-1:0]      o_filt_on,
	output logic signed [servo_pkg::COEF_W-1:0]    o_a1_0,
	output logic signed [servo_pkg::COEF_W-1:0]    o_b0_0,
	output logic signed [servo_pkg::COEF_W-1:0]    o_b1_0,
	output logic signed [servo_pkg::COEF_W-1:0]    o_a1_1,
	output logic signed [servo_pkg::COEF_W-1:0]    o_b0_1,
	output logic signed [servo_pkg::COEF_W-1:0]    o_b1_1,
	output logic        [servo_pkg::N_CH-1:0]      o_afe_gainx10,
	output logic        [servo_pkg::N_CH-1:0]      o_afe_nshdn
);

	import servo_pkg::*;

	////////////////////////////////////////////////////////////
	// sample capture
	////////////////////////////////////////////////////////////

	// free running, one sample per clk1
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_raw0 <= '0;
			o_raw1 <= '0;
		end else begin
			o_raw0 <= i_adc0_data;
			o_raw1 <= i_adc1_data;
		end
	end

	////////////////////////////////////////////////////////////
	// configuration capture
	////////////////////////////////////////////////////////////

	logic [CFG_W-1:0] cfg_q [N_CH];

	// cleared config means filters off, gain code 0
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cfg_q[0] <= '0;
			cfg_q[1] <= '0;
		end else begin
			cfg_q[0] <= i_cfg0;
			cfg_q[1] <= i_cfg1;
		end
	end

	// coefficient fields, same positions in both words
	assign o_a1_0 = cfg_q[0][CFG_A1_LSB +: COEF_W];
	assign o_b0_0 = cfg_q[0][CFG_B0_LSB +: COEF_W];
	assign o_b1_0 = cfg_q[0][CFG_B1_LSB +: COEF_W];
	assign o_a1_1 = cfg_q[1][CFG_A1_LSB +: COEF_W];
	assign o_b0_1 = cfg_q[1][CFG_B0_LSB +: COEF_W];
	assign o_b1_1 = cfg_q[1][CFG_B1_LSB +: COEF_W];

	// enable and gain decode per channel
	for (genvar ch = 0; ch < N_CH; ch++) begin : g_chan
		logic [1:0] gain_code;

		assign gain_code = cfg_q[ch][CFG_GAIN_LSB +: 2];
		assign o_filt_on[ch] = cfg_q[ch][CFG_ON_BIT];
		// x10 stage only for the two low codes
		assign o_afe_gainx10[ch] = (gain_code < 2'd2);
	end

	////////////////////////////////////////////////////////////
	// front-end shutdown
	////////////////////////////////////////////////////////////

	// held in shutdown through reset, wakes on first edge after
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_afe_nshdn <= '0;
		end else begin
			o_afe_nshdn <= '1;
		end
	end

	// AFE stays awake once the first edge out of reset has passed
	a_nshdn_awake : assert property (
		@(posedge clk1) disable iff (!i_arst_n)
		$past(i_arst_n) |-> (o_afe_nshdn == '1)
	) else $error("adc_capture: front end shut down after reset release");

endmodule

// File: source/dac_output.sv
// output side of the servo; truncates and registers the fast and slow DAC words, toggles DCI
`timescale 1ns/10ps

module dac_output #(
	parameter int SIGNAL_W = 24
) (
	input  logic                                 clk1,
	input  logic                                 i_arst_n,
	input  logic signed [SIGNAL_W-1:0]           i_error,
	input  logic signed [SIGNAL_W-1:0]           i_filt0,
	output logic        [servo_pkg::FAST_DAC_W-1:0] o_dac_fast_data,
	output logic                                 o_dac_dci,
	output logic        [servo_pkg::SLOW_DAC_W-1:0] o_dac_slow_data
);

	import servo_pkg::*;

	////////////////////////////////////////////////////////////
	// DAC words
	////////////////////////////////////////////////////////////

	logic [FAST_DAC_W-1:0] fast_word;
	logic [SLOW_DAC_W-1:0] slow_word;

	// keep the msbs, low bits dropped
	assign fast_word = i_error[SIGNAL_W-1 -: FAST_DAC_W];
	assign slow_word = i_filt0[SIGNAL_W-1 -: SLOW_DAC_W];

	// pins read zero through reset
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dac_fast_data <= '0;
			o_dac_slow_data <= '0;
		end else begin
			o_dac_fast_data <= fast_word;
			o_dac_slow_data <= slow_word;
		end
	end

	////////////////////////////////////////////////////////////
	// data clock
	////////////////////////////////////////////////////////////

	// half rate DCI for the parallel DAC
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dac_dci <= 1'b0;
		end else begin
			o_dac_dci <= ~o_dac_dci;
		end
	end

	// no missed toggles once running
	a_dci_toggle : assert property (
		@(posedge clk1) disable iff (!i_arst_n)
		$past(i_arst_n) |-> (o_dac_dci != $past(o_dac_dci))
	) else $error("dac_output: data clock failed to toggle");

endmodule

// File: source/error_path.sv
// processing part of the servo; filters both channels and registers their difference as the error
`timescale 1ns/10ps

module error_path #(
	parameter int SIGNAL_W = 24,
	parameter int COEF_W   = 35
) (
	input  logic                                clk1,
	input  logic                                i_arst_n,
	input  logic        [servo_pkg::RAW_W-1:0]  i_raw0,
	input  logic        [servo_pkg::RAW_W-1:0]  i_raw1,
	input  logic        [servo_pkg::N_CH-1:0]   i_filt_on,
	input  logic signed [COEF_W-1:0]            i_a1_0,
	input  logic signed [COEF_W-1:0]            i_b0_0,
	input  logic signed [COEF_W-1:0]            i_b1_0,
	input  logic signed [COEF_W-1:0]            i_a1_1,
	input  logic signed [COEF_W-1:0]            i_b0_1,
	input  logic signed [COEF_W-1:0]            i_b1_1,
	output logic signed [SIGNAL_W-1:0]          o_filt0,
	output logic signed [SIGNAL_W-1:0]          o_error
);

	import servo_pkg::*;

	////////////////////////////////////////////////////////////
	// alignment
	////////////////////////////////////////////////////////////

	logic signed [SIGNAL_W-1:0] align0;
	logic signed [SIGNAL_W-1:0] align1;
	logic signed [SIGNAL_W-1:0] filt1;

	// sample in the top bits, zero fill below
	assign align0 = {i_raw0, {(SIGNAL_W - RAW_W){1'b0}}};
	assign align1 = {i_raw1, {(SIGNAL_W - RAW_W){1'b0}}};

	////////////////////////////////////////////////////////////
	// per channel low-pass
	////////////////////////////////////////////////////////////

	iir_first_order #(
		.SIGNAL_W (SIGNAL_W),
		.COEF_W   (COEF_W)
	) u_iir0 (
		.clk1     (clk1),
		.i_arst_n (i_arst_n),
		.i_on     (i_filt_on[0]),
		.i_a1     (i_a1_0),
		.i_b0     (i_b0_0),
		.i_b1     (i_b1_0),
		.i_signal (align0),
		.o_signal (o_filt0)
	);

	iir_first_order #(
		.SIGNAL_W (SIGNAL_W),
		.COEF_W   (COEF_W)
	) u_iir1 (
		.clk1     (clk1),
		.i_arst_n (i_arst_n),
		.i_on     (i_filt_on[1]),
		.i_a1     (i_a1_1),
		.i_b0     (i_b0_1),
		.i_b1     (i_b1_1),
		.i_signal (align1),
		.o_signal (filt1)
	);

	////////////////////////////////////////////////////////////
	// error signal
	////////////////////////////////////////////////////////////

	// ch0 minus ch1, wraps in SIGNAL_W
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_error <= '0;
		end else begin
			o_error <= o_filt0 - filt1;
		end
	end

endmodule

// File: source/iir_first_order.sv
// first-order IIR low-pass with bypass; one instance per ADC channel inside error_path
`timescale 1ns/10ps

module iir_first_order #(
	parameter int SIGNAL_W = 24,
	parameter int COEF_W   = 35
) (
	input  logic                       clk1,
	input  logic                       i_arst_n,
	input  logic                       i_on,
	input  logic signed [COEF_W-1:0]   i_a1,
	input  logic signed [COEF_W-1:0]   i_b0,
	input  logic signed [COEF_W-1:0]   i_b1,
	input  logic signed [SIGNAL_W-1:0] i_signal,
	output logic signed [SIGNAL_W-1:0] o_signal
);

	import servo_pkg::*;

	// one product, then two guard bits for the three-term sum
	localparam int PROD_W = SIGNAL_W + COEF_W;
	localparam int ACC_W  = PROD_W + 2;

	////////////////////////////////////////////////////////////
	// filter state
	////////////////////////////////////////////////////////////

	// x[n-1]
	logic signed [SIGNAL_W-1:0] x_prev;

	// y[n-1] is the output register itself
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			x_prev <= '0;
		end else begin
			x_prev <= i_signal;
		end
	end

	////////////////////////////////////////////////////////////
	// difference equation
	////////////////////////////////////////////////////////////

	logic signed [PROD_W-1:0]   prod_b0;
	logic signed [PROD_W-1:0]   prod_b1;
	logic signed [PROD_W-1:0]   prod_a1;
	logic signed [ACC_W-1:0]    acc;
	logic signed [ACC_W-1:0]    acc_scaled;
	logic signed [SIGNAL_W-1:0] filt_next;

	// full width signed products
	assign prod_b0 = i_b0 * i_signal;
	assign prod_b1 = i_b1 * x_prev;
	assign prod_a1 = i_a1 * o_signal;

	// y[n] = b0 x[n] + b1 x[n-1] + a1 y[n-1]
	assign acc = prod_b0 + prod_b1 + prod_a1;

	// drop the coefficient fraction, keep sign
	assign acc_scaled = acc >>> COEF_FRAC;

	// wraps in SIGNAL_W
	assign filt_next = acc_scaled[SIGNAL_W-1:0];

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// bypass passes the input straight through, one edge late
	always_ff @(posedge clk1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_signal <= '0;
		end else if (i_on) begin
			o_signal <= filt_next;
		end else begin
			o_signal <= i_signal;
		end
	end

	// bypass latency is exactly one edge
	a_bypass : assert property (
		@(posedge clk1) disable iff (!i_arst_n)
		($past(i_arst_n) && !$past(i_on)) |-> (o_signal == $past(i_signal))
	) else $error("iir_first_order: bypass output differs from previous input");

endmodule

// File: source/laser_servo_top.sv
// top level of the two-channel laser servo; wires capture, error path and DAC output together
`timescale 1ns/10ps

module laser_servo_top #(
	parameter int SIGNAL_W = servo_pkg::SIGNAL_W,
	parameter int COEF_W   = servo_pkg::COEF_W
) (
	input  logic                                clk1,
	input  logic                                i_arst_n,
	input  logic [servo_pkg::RAW_W-1:0]         i_adc0_data,
	input  logic [servo_pkg::RAW_W-1:0]         i_adc1_data,
	input  logic [servo_pkg::CFG_W-1:0]         i_cfg0,
	input  logic [servo_pkg::CFG_W-1:0]         i_cfg1,
	output logic [servo_pkg::N_CH-1:0]          o_afe_gainx10,
	output logic [servo_pkg::N_CH-1:0]          o_afe_nshdn,
	output logic [servo_pkg::FAST_DAC_W-1:0]    o_dac_fast_data,
	output logic                                o_dac_dci,
	output logic [servo_pkg::SLOW_DAC_W-1:0]    o_dac_slow_data
);

	import servo_pkg::*;

	// coefficient fields are fixed by the config word layout
	if (COEF_W != servo_pkg::COEF_W || SIGNAL_W < SLOW_DAC_W) begin : g_bad_width
		$error("laser_servo_top: COEF_W must match the config word, SIGNAL_W too narrow");
	end

	////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////

	logic        [RAW_W-1:0]    raw0;
	logic        [RAW_W-1:0]    raw1;
	logic        [N_CH-1:0]     filt_on;
	logic signed [COEF_W-1:0]   a1_0;
	logic signed [COEF_W-1:0]   b0_0;
	logic signed [COEF_W-1:0]   b1_0;
	logic signed [COEF_W-1:0]   a1_1;
	logic signed [COEF_W-1:0]   b0_1;
	logic signed [COEF_W-1:0]   b1_1;
	logic signed [SIGNAL_W-1:0] filt0;
	logic signed [SIGNAL_W-1:0] error;

	// input side, 1 edge
	adc_capture u_adc_capture (
		.clk1          (clk1),
		.i_arst_n      (i_arst_n),
		.i_adc0_data   (i_adc0_data),
		.i_adc1_data   (i_adc1_data),
		.i_cfg0        (i_cfg0),
		.i_cfg1        (i_cfg1),
		.o_raw0        (raw0),
		.o_raw1        (raw1),
		.o_filt_on     (filt_on),
		.o_a1_0        (a1_0),
		.o_b0_0        (b0_0),
		.o_b1_0        (b1_0),
		.o_a1_1        (a1_1),
		.o_b0_1        (b0_1),
		.o_b1_1        (b1_1),
		.o_afe_gainx10 (o_afe_gainx10),
		.o_afe_nshdn   (o_afe_nshdn)
	);

	// filters then difference, 2 edges for error, 1 for filt0
	error_path #(
		.SIGNAL_W (SIGNAL_W),
		.COEF_W   (COEF_W)
	) u_error_path (
		.clk1      (clk1),
		.i_arst_n  (i_arst_n),
		.i_raw0    (raw0),
		.i_raw1    (raw1),
		.i_filt_on (filt_on),
		.i_a1_0    (a1_0),
		.i_b0_0    (b0_0),
		.i_b1_0    (b1_0),
		.i_a1_1    (a1_1),
		.i_b0_1    (b0_1),
		.i_b1_1    (b1_1),
		.o_filt0   (filt0),
		.o_error   (error)
	);

	// DAC pins, 1 edge
	dac_output #(
		.SIGNAL_W (SIGNAL_W)
	) u_dac_output (
		.clk1            (clk1),
		.i_arst_n        (i_arst_n),
		.i_error         (error),
		.i_filt0         (filt0),
		.o_dac_fast_data (o_dac_fast_data),
		.o_dac_dci       (o_dac_dci),
		.o_dac_slow_data (o_dac_slow_data)
	);

endmodule

// File: source/servo_pkg.sv
// widths and configuration word layout shared by the laser servo modules, imported where needed

package servo_pkg;

	////////////////////////////////////////////////////////////
	// datapath widths
	////////////////////////////////////////////////////////////

	// raw ADC sample, already parallel
	localparam int RAW_W = 16;
	// internal signal width through the filters
	localparam int SIGNAL_W = 24;
	// signed filter coefficient
	localparam int COEF_W = 35;
	// binary point of a coefficient
	localparam int COEF_FRAC = 32;

	////////////////////////////////////////////////////////////
	// per channel configuration word
	////////////////////////////////////////////////////////////

	localparam int CFG_W = 160;
	// filter enable
	localparam int CFG_ON_BIT = 0;
	// feedback coefficient a1
	localparam int CFG_A1_LSB = 16;
	// current input coefficient b0
	localparam int CFG_B0_LSB = 64;
	// previous input coefficient b1
	localparam int CFG_B1_LSB = 112;
	// front-end gain code, two bits at the top of the word
	localparam int CFG_GAIN_LSB = 152;

	////////////////////////////////////////////////////////////
	// converters
	////////////////////////////////////////////////////////////

	// parallel fast DAC
	localparam int FAST_DAC_W = 16;
	// slow DAC word
	localparam int SLOW_DAC_W = 20;
	// ADC channel count
	localparam int N_CH = 2;

endpackage

// File: tb/tb_laser_servo.sv
// self-checking testbench for laser_servo_top; applies a stimulus table against a cycle model
`timescale 1ns/10ps

module tb_laser_servo;

	import servo_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int N_ROWS     = 7;
	// row kinds
	localparam int M_FIXED = 0;
	localparam int M_STEP  = 1;
	localparam int M_RAND  = 2;
	// coefficients, 32 fraction bits
	localparam logic signed [COEF_W-1:0] C_HALF   = 35'sh0_8000_0000;
	localparam logic signed [COEF_W-1:0] C_QUART  = 35'sh0_4000_0000;
	localparam logic signed [COEF_W-1:0] C_3QUART = 35'sh0_C000_0000;
	localparam logic signed [COEF_W-1:0] C_NQUART = -35'sh0_4000_0000;

	logic                  clk1;
	logic                  i_arst_n;
	logic [RAW_W-1:0]      i_adc0_data;
	logic [RAW_W-1:0]      i_adc1_data;
	logic [CFG_W-1:0]      i_cfg0;
	logic [CFG_W-1:0]      i_cfg1;
	logic [N_CH-1:0]       o_afe_gainx10;
	logic [N_CH-1:0]       o_afe_nshdn;
	logic [FAST_DAC_W-1:0] o_dac_fast_data;
	logic                  o_dac_dci;
	logic [SLOW_DAC_W-1:0] o_dac_slow_data;

	////////////////////////////////////////////////////////////
	// stimulus table and model state
	////////////////////////////////////////////////////////////

	logic [RAW_W-1:0]      t_adc0 [N_ROWS];
	logic [RAW_W-1:0]      t_adc1 [N_ROWS];
	logic [CFG_W-1:0]      t_cfg0 [N_ROWS];
	logic [CFG_W-1:0]      t_cfg1 [N_ROWS];
	int                    t_hold [N_ROWS];
	int                    t_mode [N_ROWS];
	logic [FAST_DAC_W-1:0] t_fast [N_ROWS];
	logic [SLOW_DAC_W-1:0] t_slow [N_ROWS];
	logic [N_CH-1:0]       t_gain [N_ROWS];

	// model registers, named after the pipeline stage they mirror
	logic [RAW_W-1:0]           m_raw0;
	logic [RAW_W-1:0]           m_raw1;
	logic [CFG_W-1:0]           m_cfg0;
	logic [CFG_W-1:0]           m_cfg1;
	logic signed [SIGNAL_W-1:0] m_x0;
	logic signed [SIGNAL_W-1:0] m_x1;
	logic signed [SIGNAL_W-1:0] m_y0;
	logic signed [SIGNAL_W-1:0] m_y1;
	logic signed [SIGNAL_W-1:0] m_err;
	logic [FAST_DAC_W-1:0]      m_fast;
	logic [SLOW_DAC_W-1:0]      m_slow;
	logic                       m_dci;

	int          n_errors;
	int          n_checks;
	int          hold_sum;
	logic        table_ready;
	logic [31:0] lcg_state;

	laser_servo_top #(
		.SIGNAL_W (SIGNAL_W),
		.COEF_W   (COEF_W)
	) UUT (
		.clk1            (clk1),
		.i_arst_n        (i_arst_n),
		.i_adc0_data     (i_adc0_data),
		.i_adc1_data     (i_adc1_data),
		.i_cfg0          (i_cfg0),
		.i_cfg1          (i_cfg1),
		.o_afe_gainx10   (o_afe_gainx10),
		.o_afe_nshdn     (o_afe_nshdn),
		.o_dac_fast_data (o_dac_fast_data),
		.o_dac_dci       (o_dac_dci),
		.o_dac_slow_data (o_dac_slow_data)
	);

	// 100 ns clock
	always #(CLK_PERIOD / 2) clk1 = ~clk1;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [CFG_W-1:0] make_cfg(input logic on,
		input logic signed [COEF_W-1:0] a1, input logic signed [COEF_W-1:0] b0,
		input logic signed [COEF_W-1:0] b1, input logic [1:0] gain);
		logic [CFG_W-1:0] w;
		w = '0;
		w[CFG_ON_BIT] = on;
		w[CFG_A1_LSB +: COEF_W] = a1;
		w[CFG_B0_LSB +: COEF_W] = b0;
		w[CFG_B1_LSB +: COEF_W] = b1;
		w[CFG_GAIN_LSB +: 2] = gain;
		return w;
	endfunction

	// raw sample into the top 16 of 24 bits
	function automatic logic signed [SIGNAL_W-1:0] align(input logic [RAW_W-1:0] raw);
		logic [SIGNAL_W-1:0] v;
		v = SIGNAL_W'(raw);
		return v << (SIGNAL_W - RAW_W);
	endfunction

	// y = b0 x + b1 xp + a1 yp, floor shifted by the fraction, wrapped to 24 bits
	function automatic logic signed [SIGNAL_W-1:0] low_pass(input logic [CFG_W-1:0] cfg,
		input logic signed [SIGNAL_W-1:0] x, input logic signed [SIGNAL_W-1:0] xp,
		input logic signed [SIGNAL_W-1:0] yp);
		longint a1;
		longint b0;
		longint b1;
		longint acc;
		if (!cfg[CFG_ON_BIT]) begin
			return x;
		end
		a1 = longint'($signed(cfg[CFG_A1_LSB +: COEF_W]));
		b0 = longint'($signed(cfg[CFG_B0_LSB +: COEF_W]));
		b1 = longint'($signed(cfg[CFG_B1_LSB +: COEF_W]));
		acc = b0 * longint'(x) + b1 * longint'(xp) + a1 * longint'(yp);
		acc = acc >>> COEF_FRAC;
		return acc[SIGNAL_W-1:0];
	endfunction

	// x10 stage for gain codes 0 and 1
	function automatic logic [N_CH-1:0] gain_of(input logic [CFG_W-1:0] c0,
		input logic [CFG_W-1:0] c1);
		return {c1[CFG_GAIN_LSB +: 2] < 2'd2, c0[CFG_GAIN_LSB +: 2] < 2'd2};
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic set_row(input int r, input logic [RAW_W-1:0] a0,
		input logic [RAW_W-1:0] a1, input logic [CFG_W-1:0] c0,
		input logic [CFG_W-1:0] c1, input int hold, input int mode);
		logic signed [SIGNAL_W-1:0] x0;
		logic signed [SIGNAL_W-1:0] diff;
		t_adc0[r] = a0;
		t_adc1[r] = a1;
		t_cfg0[r] = c0;
		t_cfg1[r] = c1;
		t_hold[r] = hold;
		t_mode[r] = mode;
		// bypass values straight from the alignment and wrap rules
		x0 = align(a0);
		diff = x0 - align(a1);
		t_fast[r] = diff[SIGNAL_W-1 -: FAST_DAC_W];
		t_slow[r] = x0[SIGNAL_W-1 -: SLOW_DAC_W];
		t_gain[r] = gain_of(c0, c1);
		hold_sum += hold;
	endtask

	// one clk1 edge of the reference, stages updated from the back
	task automatic model_step(input logic [RAW_W-1:0] a0, input logic [RAW_W-1:0] a1,
		input logic [CFG_W-1:0] c0, input logic [CFG_W-1:0] c1);
		logic signed [SIGNAL_W-1:0] y0_next;
		logic signed [SIGNAL_W-1:0] y1_next;
		m_fast = m_err[SIGNAL_W-1 -: FAST_DAC_W];
		m_slow = m_y0[SIGNAL_W-1 -: SLOW_DAC_W];
		m_err = m_y0 - m_y1;
		y0_next = low_pass(m_cfg0, align(m_raw0), m_x0, m_y0);
		y1_next = low_pass(m_cfg1, align(m_raw1), m_x1, m_y1);
		m_x0 = align(m_raw0);
		m_x1 = align(m_raw1);
		m_y0 = y0_next;
		m_y1 = y1_next;
		m_raw0 = a0;
		m_raw1 = a1;
		m_cfg0 = c0;
		m_cfg1 = c1;
		m_dci = ~m_dci;
	endtask

	// drive on the falling edge, compare on the next falling edge
	task automatic run_cycle(input logic [RAW_W-1:0] a0, input logic [RAW_W-1:0] a1,
		input logic [CFG_W-1:0] c0, input logic [CFG_W-1:0] c1);
		i_adc0_data = a0;
		i_adc1_data = a1;
		i_cfg0 = c0;
		i_cfg1 = c1;
		@(posedge clk1);
		@(negedge clk1);
		model_step(a0, a1, c0, c1);
		check("fast DAC against model", o_dac_fast_data, m_fast);
		check("slow DAC against model", o_dac_slow_data, m_slow);
		check("AFE gain against model", o_afe_gainx10, gain_of(m_cfg0, m_cfg1));
		check("data clock toggle", o_dac_dci, m_dci);
		check("AFE awake", o_afe_nshdn, 2'b11);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [RAW_W-1:0]      a0;
		logic [RAW_W-1:0]      a1;
		logic [SLOW_DAC_W-1:0] gap;
		clk1 = 1'b0;
		i_arst_n = 1'b0;
		i_adc0_data = '0;
		i_adc1_data = '0;
		i_cfg0 = '0;
		i_cfg1 = '0;
		n_errors = 0;
		n_checks = 0;
		hold_sum = 0;
		lcg_state = 32'hd11b_83f5;
		// model matches the cleared pipeline
		m_raw0 = '0;
		m_raw1 = '0;
		m_cfg0 = '0;
		m_cfg1 = '0;
		m_x0 = '0;
		m_x1 = '0;
		m_y0 = '0;
		m_y1 = '0;
		m_err = '0;
		m_fast = '0;
		m_slow = '0;
		m_dci = 1'b0;

		// bypass rows walk the gain codes, ch1 in reverse
		set_row(0, 16'h1234, 16'h0F00, make_cfg(0, 0, 0, 0, 2'd0),
			make_cfg(0, 0, 0, 0, 2'd3), 6, M_FIXED);
		set_row(1, 16'h0100, 16'h8000, make_cfg(0, 0, 0, 0, 2'd1),
			make_cfg(0, 0, 0, 0, 2'd2), 6, M_FIXED);
		set_row(2, 16'hFFFF, 16'h0001, make_cfg(0, 0, 0, 0, 2'd2),
			make_cfg(0, 0, 0, 0, 2'd1), 6, M_FIXED);
		set_row(3, 16'h7FFF, 16'h7FFF, make_cfg(0, 0, 0, 0, 2'd3),
			make_cfg(0, 0, 0, 0, 2'd0), 6, M_FIXED);
		// step on ch0, half input plus half feedback
		set_row(4, 16'h4000, 16'h1000, make_cfg(1, C_HALF, C_HALF, 0, 2'd0),
			make_cfg(0, 0, 0, 0, 2'd3), 40, M_STEP);
		// random stream, mixed signs on ch1
		set_row(5, 16'h0000, 16'h0000, make_cfg(1, C_HALF, C_QUART, C_QUART, 2'd1),
			make_cfg(1, C_HALF, C_3QUART, C_NQUART, 2'd2), 200, M_RAND);
		set_row(6, 16'h0055, 16'hAA00, make_cfg(0, 0, 0, 0, 2'd0),
			make_cfg(0, 0, 0, 0, 2'd0), 6, M_FIXED);
		table_ready = 1'b1;

		// reset for 4 cycles
		repeat (4) @(posedge clk1);
		@(negedge clk1);
		check("fast DAC in reset", o_dac_fast_data, '0);
		check("slow DAC in reset", o_dac_slow_data, '0);
		check("AFE shutdown in reset", o_afe_nshdn, '0);
		check("data clock in reset", o_dac_dci, '0);
		i_arst_n = 1'b1;

		for (int r = 0; r < N_ROWS; r++) begin
			// e counts edges after the row was applied
			for (int e = 0; e < t_hold[r]; e++) begin
				a0 = t_adc0[r];
				a1 = t_adc1[r];
				if (t_mode[r] == M_RAND) begin
					lcg_state = lcg_next(lcg_state);
					a0 = lcg_state[31:16];
					lcg_state = lcg_next(lcg_state);
					a1 = lcg_state[31:16];
				end
				run_cycle(a0, a1, t_cfg0[r], t_cfg1[r]);
				check("AFE gain from table", o_afe_gainx10, t_gain[r]);
				// slow after 2 edges, fast after 3
				if (t_mode[r] == M_FIXED && e >= 2) begin
					check("slow DAC from table", o_dac_slow_data, t_slow[r]);
				end
				if (t_mode[r] == M_FIXED && e >= 3) begin
					check("fast DAC from table", o_dac_fast_data, t_fast[r]);
				end
			end
			// floor rounding leaves the settled step at most one lsb low
			if (t_mode[r] == M_STEP) begin
				gap = t_slow[r] - o_dac_slow_data;
				check("step settled at input", gap <= 1, 1'b1);
			end
		end

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog, sized from the table
	initial begin
		wait (table_ready === 1'b1);
		#((hold_sum + 20) * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", hold_sum + 20);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
source/servo_pkg.sv
source/adc_capture.sv
source/iir_first_order.sv
source/error_path.sv
source/dac_output.sv
source/laser_servo_top.sv
tb/tb_laser_servo.sv
